// ==== logic/fx2_macros.svh ====
`ifndef FX2_MACROS_SVH
`define FX2_MACROS_SVH

// FIFO_ADR codes for the two endpoints used here
`define FX2_EP2_ADR 2'b00 // OUT endpoint, host to fpga
`define FX2_EP6_ADR 2'b10 // IN endpoint, fpga to host

// loopback storage, keep a power of two so the pointers wrap for free
`define FX2_BUF_DEPTH 16

// upper LED nibble is unused, held lit
`define FX2_LED_FILL 4'b1111

`endif

// ==== logic/fx2_pkg.sv ====
package fx2_pkg;

	// one word on the FX2 16-bit slave FIFO bus
	typedef logic [15:0] fx2_word_t;

	// endpoint select driven onto FIFO_ADR
	typedef logic [1:0] fifo_adr_t;

	// bus ownership states of the port arbiter
	typedef enum logic [1:0]
	{
		ARB_IDLE,   // choosing the next endpoint
		ARB_SETTLE, // FIFO_ADR just changed, give it a cycle
		ARB_READ,   // EP2 reader owns the bus
		ARB_WRITE   // EP6 writer owns the bus
	} arb_state_t;

	// grants from the arbiter, at most one bit high
	typedef struct packed
	{
		logic rd_grant; // to ep2_reader
		logic wr_grant; // to ep6_writer
	} port_grant_t;

endpackage

// ==== logic/fifo_port_arbiter.sv ====
`timescale 1ns/1ps
`include "fx2_macros.svh"

module fifo_port_arbiter
	import fx2_pkg::*;
(
	input  logic        IFCLK,
	input  logic        rst_n,
	input  logic        FLAGA,       // EP2 has data
	input  logic        FLAGC,       // EP6 has room
	input  logic        pattern_sel,
	input  logic        buf_empty,
	input  logic        buf_full,
	input  logic        rd_busy,
	input  logic        wr_busy,
	output port_grant_t grant,
	output fifo_adr_t   FIFO_ADR
);

	arb_state_t state;
	logic pend_rd; // port waiting behind the settle cycle, 1 = reader
	logic hold;    // first grant cycle, owner has not raised busy yet
	logic want_rd;
	logic want_wr;

	// read only makes sense in loopback and with space to put words
	assign want_rd = FLAGA && !pattern_sel && !buf_full;
	assign want_wr = FLAGC && (pattern_sel || !buf_empty);

	// grant drops in the same cycle the owner's busy falls,
	// so an idle owner never sees a stale grant and restarts
	assign grant.rd_grant = (state == ARB_READ) && (hold || rd_busy);
	assign grant.wr_grant = (state == ARB_WRITE) && (hold || wr_busy);

	always_ff @(posedge IFCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ARB_IDLE;
			FIFO_ADR <= `FX2_EP2_ADR;
			pend_rd <= 1'b0;
			hold <= 1'b0;
		end
		else
		begin
			case (state)
				ARB_IDLE:
				begin
					hold <= 1'b1; // armed for whichever grant comes next
					if (want_rd) // read wins a tie
					begin
						pend_rd <= 1'b1;
						if (FIFO_ADR != `FX2_EP2_ADR)
						begin
							FIFO_ADR <= `FX2_EP2_ADR;
							state <= ARB_SETTLE;
						end
						else
							state <= ARB_READ;
					end
					else if (want_wr)
					begin
						pend_rd <= 1'b0;
						if (FIFO_ADR != `FX2_EP6_ADR)
						begin
							FIFO_ADR <= `FX2_EP6_ADR;
							state <= ARB_SETTLE;
						end
						else
							state <= ARB_WRITE;
					end
				end
				// one IFCLK for the address to settle, needed at 48 MHz
				ARB_SETTLE: state <= pend_rd ? ARB_READ : ARB_WRITE;
				ARB_READ:
				begin
					hold <= 1'b0;
					if (!hold && !rd_busy) // reader finished its run
						state <= ARB_IDLE;
				end
				ARB_WRITE:
				begin
					hold <= 1'b0;
					if (!hold && !wr_busy)
						state <= ARB_IDLE;
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// a grant while the other port is still busy would put both on FX2_FD
	a_grant_exclusive: assert property (@(posedge IFCLK) disable iff (!rst_n)
		!(grant.rd_grant && wr_busy) && !(grant.wr_grant && rd_busy));

	// a fresh grant must always see a settled address
	a_grant_settled: assert property (@(posedge IFCLK) disable iff (!rst_n)
		$rose(grant.rd_grant || grant.wr_grant) |-> $stable(FIFO_ADR));

endmodule

// ==== logic/ep2_reader.sv ====
`timescale 1ns/1ps

module ep2_reader
	import fx2_pkg::*;
(
	input  logic      IFCLK,
	input  logic      rst_n,
	input  logic      rd_grant,
	input  logic      FLAGA,     // EP2 not empty
	input  logic      buf_full,
	input  fx2_word_t rd_data,   // FX2_FD as seen by the fpga
	output logic      SLOE,      // active low output enable to the FX2
	output logic      SLRD,      // active low read strobe
	output logic      push,
	output logic      rd_busy,
	output fx2_word_t push_data
);

	typedef enum logic [1:0]
	{
		RD_IDLE,
		RD_OE,   // FX2 turns its drivers on
		RD_READ  // one word per cycle while allowed
	} rd_state_t;

	rd_state_t state;
	logic rd_go;

	// flags are checked in the cycle itself, a registered strobe would
	// read one word past the end when FLAGA drops after the last pop
	assign rd_go = (state == RD_READ) && FLAGA && !buf_full;

	assign SLOE = (state == RD_IDLE);
	assign SLRD = !rd_go;
	assign push = rd_go;          // word lands in the buffer on this edge
	assign push_data = rd_data;
	assign rd_busy = (state != RD_IDLE);

	always_ff @(posedge IFCLK or negedge rst_n)
	begin
		if (!rst_n)
			state <= RD_IDLE;
		else
		begin
			case (state)
				RD_IDLE:
				begin
					if (rd_grant)
						state <= RD_OE;
				end
				RD_OE: state <= RD_READ; // data valid from the next cycle
				RD_READ:
				begin
					if (!rd_go) // EP2 drained or buffer full
						state <= RD_IDLE;
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	// FD is valid only a cycle after SLOE falls, reading earlier returns garbage
	a_slrd_needs_sloe: assert property (@(posedge IFCLK) disable iff (!rst_n)
		!SLRD |-> (!SLOE && $past(!SLOE)));

endmodule

// ==== logic/loop_buffer.sv ====
`timescale 1ns/1ps
`include "fx2_macros.svh"

module loop_buffer
	import fx2_pkg::*;
(
	input  logic      IFCLK,
	input  logic      rst_n,
	input  logic      pattern_sel, // 1 = counter, 0 = loopback
	input  logic      push,
	input  logic      pop,
	input  fx2_word_t push_data,
	output fx2_word_t out_data,
	output logic      buf_empty,
	output logic      buf_full
);

	localparam int AW = $clog2(`FX2_BUF_DEPTH);

	fx2_word_t mem [`FX2_BUF_DEPTH];
	logic [AW:0] wr_ptr; // extra msb tells full from empty
	logic [AW:0] rd_ptr;
	fx2_word_t pat_cnt;   // counter pattern source

	assign buf_empty = (wr_ptr == rd_ptr);
	assign buf_full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// head of the fifo is read without a register, the writer pops
	// in the same cycle it puts the word on the bus
	assign out_data = pattern_sel ? pat_cnt : mem[rd_ptr[AW-1:0]];

	always_ff @(posedge IFCLK)
	begin
		if (push)
			mem[wr_ptr[AW-1:0]] <= push_data;
	end

	always_ff @(posedge IFCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			pat_cnt <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
			begin
				if (pattern_sel)
					pat_cnt <= pat_cnt + 16'd1; // wraps at 2^16
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// reader gates push on buf_full, an overrun means that gating broke
	a_no_overflow: assert property (@(posedge IFCLK) disable iff (!rst_n)
		push |-> !buf_full);

	// writer gates pop on data being there
	a_no_underflow: assert property (@(posedge IFCLK) disable iff (!rst_n)
		(pop && !pattern_sel) |-> !buf_empty);

endmodule

// ==== logic/ep6_writer.sv ====
`timescale 1ns/1ps

module ep6_writer
	import fx2_pkg::*;
(
	input  logic IFCLK,
	input  logic rst_n,
	input  logic wr_grant,
	input  logic FLAGC,       // EP6 has room
	input  logic pattern_sel,
	input  logic buf_empty,
	output logic SLWR,        // active low write strobe
	output logic drive_en,    // fpga owns FX2_FD
	output logic PKEND,       // active low packet end
	output logic pop,
	output logic wr_busy
);

	typedef enum logic [1:0]
	{
		WR_IDLE,
		WR_BURST,  // bus driven, SLWR low whenever a word can go
		WR_COMMIT  // PKEND pulse for a short loopback packet
	} wr_state_t;

	wr_state_t state;
	logic avail; // something to send
	logic wr_go;

	assign avail = pattern_sel || !buf_empty; // counter never runs dry

	// FLAGC is looked at in the cycle itself so a full EP6 never
	// takes a word, no word is popped and none goes missing
	assign wr_go = (state == WR_BURST) && FLAGC && avail;

	assign SLWR = !wr_go;
	assign pop = wr_go;
	assign drive_en = (state == WR_BURST);
	assign PKEND = (state != WR_COMMIT);
	assign wr_busy = (state != WR_IDLE);

	always_ff @(posedge IFCLK or negedge rst_n)
	begin
		if (!rst_n)
			state <= WR_IDLE;
		else
		begin
			case (state)
				WR_IDLE:
				begin
					if (wr_grant)
						state <= WR_BURST; // start driving the bus
				end
				WR_BURST:
				begin
					if (!wr_go)
					begin
						// buffer ran dry in loopback, flush the short packet
						if (!pattern_sel && buf_empty)
							state <= WR_COMMIT;
						else
							state <= WR_IDLE; // EP6 full, try again later
					end
				end
				WR_COMMIT: state <= WR_IDLE;
				default: state <= WR_IDLE;
			endcase
		end
	end

	// driving FX2_FD outside the EP6 grant would clash with the FX2 read data
	a_drive_granted: assert property (@(posedge IFCLK) disable iff (!rst_n)
		drive_en |-> wr_grant);

endmodule

// ==== logic/fx2_slave_fifo.sv ====
`timescale 1ns/1ps
`include "fx2_macros.svh"

module fx2_slave_fifo
	import fx2_pkg::*;
(
	input  logic            IFCLK,
	input  logic            rst_n,
	input  logic            FLAGA,       // EP2 has data
	input  logic            FLAGB,       // only shown on LEDS
	input  logic            FLAGC,       // EP6 has room
	inout  wire  fx2_word_t FX2_FD,
	output logic            SLWR,
	output logic            SLRD,
	output logic            SLOE,
	output logic            PKEND,
	output fifo_adr_t       FIFO_ADR,
	output logic [7:0]      LEDS,
	input  logic            pattern_sel  // 1 = counter, 0 = loopback
);

	port_grant_t grant;
	logic rd_busy;
	logic wr_busy;
	logic push;
	logic pop;
	logic buf_empty;
	logic buf_full;
	logic drive_en;
	fx2_word_t push_data;
	fx2_word_t out_data;

	// fpga drives the bus only during a write burst
	assign FX2_FD = drive_en ? out_data : 'z;

	assign LEDS = {`FX2_LED_FILL, pattern_sel, FLAGC, FLAGB, FLAGA};

	fifo_port_arbiter fifo_port_arbiter_i (
		.IFCLK       (IFCLK),
		.rst_n       (rst_n),
		.FLAGA       (FLAGA),
		.FLAGC       (FLAGC),
		.pattern_sel (pattern_sel),
		.buf_empty   (buf_empty),
		.buf_full    (buf_full),
		.rd_busy     (rd_busy),
		.wr_busy     (wr_busy),
		.grant       (grant),
		.FIFO_ADR    (FIFO_ADR)
	);

	ep2_reader ep2_reader_i (
		.IFCLK     (IFCLK),
		.rst_n     (rst_n),
		.rd_grant  (grant.rd_grant),
		.FLAGA     (FLAGA),
		.buf_full  (buf_full),
		.rd_data   (FX2_FD),
		.SLOE      (SLOE),
		.SLRD      (SLRD),
		.push      (push),
		.rd_busy   (rd_busy),
		.push_data (push_data)
	);

	loop_buffer loop_buffer_i (
		.IFCLK       (IFCLK),
		.rst_n       (rst_n),
		.pattern_sel (pattern_sel),
		.push        (push),
		.pop         (pop),
		.push_data   (push_data),
		.out_data    (out_data),
		.buf_empty   (buf_empty),
		.buf_full    (buf_full)
	);

	ep6_writer ep6_writer_i (
		.IFCLK       (IFCLK),
		.rst_n       (rst_n),
		.wr_grant    (grant.wr_grant),
		.FLAGC       (FLAGC),
		.pattern_sel (pattern_sel),
		.buf_empty   (buf_empty),
		.SLWR        (SLWR),
		.drive_en    (drive_en),
		.PKEND       (PKEND),
		.pop         (pop),
		.wr_busy     (wr_busy)
	);

	// FX2 drives FD while SLOE is low, the two sides must never overlap
	a_no_bus_fight: assert property (@(posedge IFCLK) disable iff (!rst_n)
		!(drive_en && !SLOE));

	a_no_rd_wr_overlap: assert property (@(posedge IFCLK) disable iff (!rst_n)
		!(!SLRD && !SLWR));

endmodule

// ==== tests/fx2_model.sv ====
`timescale 1ns/1ps
`include "fx2_macros.svh"

module fx2_model
	import fx2_pkg::*;
(
	input  logic            IFCLK,
	output logic            FLAGA,      // EP2 not empty
	output logic            FLAGC,      // EP6 below capacity
	inout  wire  fx2_word_t FX2_FD,
	input  logic            SLRD,
	input  logic            SLWR,
	input  logic            SLOE,
	input  logic            PKEND,
	input  fifo_adr_t       FIFO_ADR,
	input  logic            load,       // host queues load_data into EP2
	input  fx2_word_t       load_data,
	input  logic            drain,      // host empties EP6
	input  logic [8:0]      ep6_cap
);

	fx2_word_t ep2_mem [512];
	fx2_word_t ep6_log [512]; // every word ever written, a drain only moves ep6_rd
	logic [8:0] ep2_wr = '0;
	logic [8:0] ep2_rd = '0;
	logic [8:0] ep6_wr = '0;
	logic [8:0] ep6_rd = '0;
	logic [8:0] ep6_level;
	int pkend_cnt = 0;

	// all state moves on NBAs, so flags and data change only after the edge
	assign FLAGA = (ep2_wr != ep2_rd);
	assign ep6_level = ep6_wr - ep6_rd;
	assign FLAGC = (ep6_level < ep6_cap);
	assign FX2_FD = (!SLOE && FIFO_ADR == `FX2_EP2_ADR) ? ep2_mem[ep2_rd] : 'z;

	always @(posedge IFCLK)
	begin
		if (load)
		begin
			ep2_mem[ep2_wr] <= load_data;
			ep2_wr <= ep2_wr + 9'd1;
		end
		if (!SLRD && FLAGA) // a strobe on an empty EP2 returns nothing
			ep2_rd <= ep2_rd + 9'd1;
		if (!SLWR && FIFO_ADR == `FX2_EP6_ADR)
		begin
			ep6_log[ep6_wr] <= FX2_FD;
			ep6_wr <= ep6_wr + 9'd1;
		end
		if (drain)
			ep6_rd <= ep6_wr; // a word landing on this edge stays queued
		if (!PKEND)
			pkend_cnt <= pkend_cnt + 1;
	end

endmodule

// ==== tests/fx2_tb.sv ====
`timescale 1ns/1ps

module fx2_tb
	import fx2_pkg::*;
();

	localparam int CNT_WORDS = 64;
	localparam int BP_WORDS = 40;
	localparam int BP_CAP = 5;
	localparam int LB_WORDS = 12;
	localparam int DEEP_WORDS = 40;
	// 20 cycles per word over all tests, margin covers reset and the LED sweep
	localparam int WD_CYCLES = (CNT_WORDS + BP_WORDS + LB_WORDS + DEEP_WORDS) * 20 + 500;

	logic IFCLK = 1'b0;
	logic rst_n;
	logic pattern_sel;
	logic led_mode;        // flags come from led_flags instead of the model
	logic [2:0] led_flags; // {FLAGC, FLAGB, FLAGA}
	logic load;
	fx2_word_t load_data;
	logic drain;
	logic [8:0] ep6_cap;
	integer seed;
	int errors = 0;
	fx2_word_t exp_cnt;    // next counter word EP6 should see
	fx2_word_t exp_words [64];

	wire fx2_word_t fx2_fd;
	logic model_flaga;
	logic model_flagc;
	logic flaga;
	logic flagb;
	logic flagc;
	logic slwr;
	logic slrd;
	logic sloe;
	logic pkend;
	fifo_adr_t fifo_adr;
	logic [7:0] leds;

	assign flaga = led_mode ? led_flags[0] : model_flaga;
	assign flagb = led_mode ? led_flags[1] : 1'b0;
	assign flagc = led_mode ? led_flags[2] : model_flagc;

	always #5 IFCLK = ~IFCLK; // 100 MHz

	fx2_slave_fifo fx2_slave_fifo_i (
		.IFCLK       (IFCLK),
		.rst_n       (rst_n),
		.FLAGA       (flaga),
		.FLAGB       (flagb),
		.FLAGC       (flagc),
		.FX2_FD      (fx2_fd),
		.SLWR        (slwr),
		.SLRD        (slrd),
		.SLOE        (sloe),
		.PKEND       (pkend),
		.FIFO_ADR    (fifo_adr),
		.LEDS        (leds),
		.pattern_sel (pattern_sel)
	);

	fx2_model fx2_model_i (
		.IFCLK     (IFCLK),
		.FLAGA     (model_flaga),
		.FLAGC     (model_flagc),
		.FX2_FD    (fx2_fd),
		.SLRD      (slrd),
		.SLWR      (slwr),
		.SLOE      (sloe),
		.PKEND     (pkend),
		.FIFO_ADR  (fifo_adr),
		.load      (load),
		.load_data (load_data),
		.drain     (drain),
		.ep6_cap   (ep6_cap)
	);

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("error at %0t ns: %s", $time, what);
	endtask

	function automatic int words_since(input int start);
		return int'(fx2_model_i.ep6_wr) - start;
	endfunction

	function automatic fx2_word_t ep6_word(input int idx);
		return fx2_model_i.ep6_log[9'(idx)];
	endfunction

	task automatic wait_for_words(input int start, input int count, input int max_cycles);
		int waited;
		waited = 0;
		while (words_since(start) < count && waited < max_cycles)
		begin
			@(negedge IFCLK);
			waited++;
		end
		if (words_since(start) < count)
			report_failure($sformatf("EP6 got %0d of %0d words before the wait ran out",
				words_since(start), count));
	endtask

	task automatic wait_ep6_full(input int max_cycles);
		int waited;
		waited = 0;
		@(negedge IFCLK);
		while (flagc && waited < max_cycles)
		begin
			@(negedge IFCLK);
			waited++;
		end
		if (flagc)
			report_failure("EP6 never filled up after a drain");
	endtask

	task automatic check_bus_idle();
		check("SLWR", 32'(slwr), 32'(1'b1));
		check("SLRD", 32'(slrd), 32'(1'b1));
		check("SLOE", 32'(sloe), 32'(1'b1));
		check("PKEND", 32'(pkend), 32'(1'b1));
		check("drive_en", 32'(fx2_slave_fifo_i.drive_en), 32'(1'b0)); // FX2_FD released
		check("FIFO_ADR", 32'(fifo_adr), 32'(2'b00));
	endtask

	task automatic reset_sequence();
		repeat (15) @(posedge IFCLK);
		@(negedge IFCLK);
		check_bus_idle();
		@(posedge IFCLK);
		rst_n <= 1'b1; // 16th edge
		@(negedge IFCLK);
		check_bus_idle();
	endtask

	task automatic counter_stream();
		int start;
		start = words_since(0);
		@(posedge IFCLK);
		pattern_sel <= 1'b1;
		ep6_cap <= 9'(CNT_WORDS);
		wait_for_words(start, CNT_WORDS, CNT_WORDS * 20);
		repeat (8) @(negedge IFCLK); // a full EP6 must stop the burst
		check("EP6 word count", 32'(words_since(start)), 32'(CNT_WORDS));
		for (int i = 0; i < CNT_WORDS; i++)
		begin
			check($sformatf("EP6 counter word %0d", i), 32'(ep6_word(start + i)), 32'(exp_cnt));
			exp_cnt = exp_cnt + 16'd1;
		end
	endtask

	task automatic backpressure_drain();
		int start;
		int rounds;
		start = words_since(0);
		rounds = 0;
		@(posedge IFCLK);
		ep6_cap <= 9'(BP_CAP);
		// host drains a tiny EP6 over and over, the counter must not skip
		while (words_since(start) < BP_WORDS && rounds < BP_WORDS)
		begin
			@(posedge IFCLK);
			drain <= 1'b1;
			@(posedge IFCLK);
			drain <= 1'b0;
			wait_ep6_full(BP_CAP * 20);
			rounds++;
		end
		check("EP6 word count", 32'(words_since(start)), 32'(BP_WORDS));
		for (int i = 0; i < BP_WORDS; i++)
		begin
			check($sformatf("EP6 counter word %0d", i), 32'(ep6_word(start + i)), 32'(exp_cnt));
			exp_cnt = exp_cnt + 16'd1;
		end
		repeat (4) @(posedge IFCLK);
	endtask

	task automatic loopback_stream(input int n);
		int start;
		int pk_start;
		int waited;
		start = words_since(0);
		pk_start = fx2_model_i.pkend_cnt;
		waited = 0;
		@(posedge IFCLK);
		pattern_sel <= 1'b0;
		ep6_cap <= 9'd256;
		drain <= 1'b1;
		@(posedge IFCLK);
		drain <= 1'b0;
		for (int i = 0; i < n; i++)
		begin
			exp_words[i] = 16'($random(seed));
			load <= 1'b1;
			load_data <= exp_words[i];
			@(posedge IFCLK);
		end
		load <= 1'b0;
		wait_for_words(start, n, n * 20);
		for (int i = 0; i < n; i++)
			check($sformatf("EP6 loopback word %0d", i), 32'(ep6_word(start + i)),
				32'(exp_words[i]));
		while (fx2_model_i.pkend_cnt == pk_start && waited < 20)
		begin
			@(negedge IFCLK);
			waited++;
		end
		if (fx2_model_i.pkend_cnt == pk_start)
			report_failure("no PKEND pulse after the last loopback word");
		check("EP6 word count", 32'(words_since(start)), 32'(n));
	endtask

	task automatic led_sweep();
		@(posedge IFCLK);
		rst_n <= 1'b0; // FSMs parked, forced flags start no bus traffic
		led_mode <= 1'b1;
		for (int sel = 0; sel < 2; sel++)
		begin
			for (int f = 0; f < 8; f++)
			begin
				@(posedge IFCLK);
				pattern_sel <= sel[0];
				led_flags <= f[2:0];
				@(negedge IFCLK);
				check("LEDS[2:0]", 32'(leds[2:0]), 32'(f[2:0]));
				check("LEDS[3]", 32'(leds[3]), 32'(sel[0]));
				check("LEDS[7:4]", 32'(leds[7:4]), 32'(4'b1111));
			end
		end
	endtask

	// protocol rules, looked at every cycle outside reset
	always @(negedge IFCLK)
	begin
		if (rst_n && !flagc)
			check("SLWR while FLAGC low", 32'(slwr), 32'(1'b1));
		if (rst_n && !slrd)
			check("SLWR while SLRD low", 32'(slwr), 32'(1'b1));
	end

	initial
	begin
		#(WD_CYCLES * 10);
		$display("timeout: run still going after %0d cycles", WD_CYCLES);
		$display("errors: %0d", errors);
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		seed = 32'ha9bd_226f;
		exp_cnt = 16'd0; // counter is cleared by reset
		rst_n = 1'b0;
		pattern_sel = 1'b0;
		led_mode = 1'b0;
		led_flags = 3'b000;
		load = 1'b0;
		load_data = '0;
		drain = 1'b0;
		ep6_cap = 9'd0;
		reset_sequence();
		counter_stream();
		backpressure_drain();
		loopback_stream(LB_WORDS);
		loopback_stream(DEEP_WORDS); // more than the buffer holds
		led_sweep();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+logic
logic/fx2_pkg.sv
logic/fifo_port_arbiter.sv
logic/ep2_reader.sv
logic/loop_buffer.sv
logic/ep6_writer.sv
logic/fx2_slave_fifo.sv
tests/fx2_model.sv
tests/fx2_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fx2_tb
FILELIST  = compile.f
BUILD     = obj_dir
BIN       = $(BUILD)/V$(TOP)
LOG       = sim.log
PASS_MSG  = All tests passed!

SRCS = $(shell grep -v '^+' $(FILELIST))
HDRS = $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
